/* rtl/id_pkg.sv */
package id_pkg;

    // ------------------------------------------------------------
    // widths and instruction fields
    // ------------------------------------------------------------
    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int NUM_REGS  = 1 << REG_AW;
    localparam int IMM_W     = 16;

    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;   // funct sits below this

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // primary opcodes
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_ADDI    = 6'h08,
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0a,
        OPC_SLTIU   = 6'h0b,
        OPC_ANDI    = 6'h0c,
        OPC_ORI     = 6'h0d,
        OPC_XORI    = 6'h0e,
        OPC_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // ------------------------------------------------------------
    // stage structs
    // ------------------------------------------------------------
    typedef struct packed {
        alu_op_e   alu_op;
        logic      we;
        reg_addr_t waddr;
        logic      re1;
        logic      re2;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        word_t     imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      we;
        reg_addr_t waddr;
        word_t     op1;
        word_t     op2;
    } id_ex_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import id_pkg::*; (
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    opcode_e          opcode;
    funct_e           funct;
    reg_addr_t        rs;
    reg_addr_t        rt;
    reg_addr_t        rd;
    reg_addr_t        shamt;
    logic [IMM_W-1:0] imm16;

    word_t            imm_zext;
    word_t            imm_sext;
    word_t            imm_lui;

    alu_op_e          r_op;     // op picked by funct
    logic             r_fixed;  // shamt form of a shift
    logic             i_type;

    // ------------------------------------------------------------
    // field split
    // ------------------------------------------------------------
    assign opcode = opcode_e'(inst_i[XLEN-1:OPC_LSB]);
    assign funct  = funct_e'(inst_i[SHAMT_LSB-1:0]);
    assign rs     = inst_i[RS_LSB +: REG_AW];
    assign rt     = inst_i[RT_LSB +: REG_AW];
    assign rd     = inst_i[RD_LSB +: REG_AW];
    assign shamt  = inst_i[SHAMT_LSB +: REG_AW];
    assign imm16  = inst_i[IMM_W-1:0];

    assign imm_zext = {{(XLEN-IMM_W){1'b0}}, imm16};
    assign imm_sext = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign imm_lui  = {imm16, {(XLEN-IMM_W){1'b0}}};

    // funct to alu op; ADD/SUB share the unsigned datapath
    always_comb begin
        r_op    = ALU_NOP;
        r_fixed = 1'b0;
        case (funct)
            FN_SLL: begin
                r_op    = ALU_SLL;
                r_fixed = 1'b1;
            end
            FN_SRL: begin
                r_op    = ALU_SRL;
                r_fixed = 1'b1;
            end
            FN_SRA: begin
                r_op    = ALU_SRA;
                r_fixed = 1'b1;
            end
            FN_SLLV:         r_op = ALU_SLL;
            FN_SRLV:         r_op = ALU_SRL;
            FN_SRAV:         r_op = ALU_SRA;
            FN_ADD, FN_ADDU: r_op = ALU_ADD;
            FN_SUB, FN_SUBU: r_op = ALU_SUB;
            FN_AND:          r_op = ALU_AND;
            FN_OR:           r_op = ALU_OR;
            FN_XOR:          r_op = ALU_XOR;
            FN_NOR:          r_op = ALU_NOR;
            FN_SLT:          r_op = ALU_SLT;
            FN_SLTU:         r_op = ALU_SLTU;
            default:         r_op = ALU_NOP;
        endcase
    end

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_NOP;
        ctrl_o.waddr  = rd;
        ctrl_o.raddr1 = rs;
        ctrl_o.raddr2 = rt;
        i_type        = 1'b0;

        case (opcode)
            OPC_SPECIAL: begin
                if (r_fixed && rs == '0) begin
                    ctrl_o.alu_op = r_op;
                    ctrl_o.we     = 1'b1;
                    ctrl_o.re2    = 1'b1;
                    ctrl_o.imm    = word_t'(shamt);  // shift amount via op1
                end else if (!r_fixed && r_op != ALU_NOP && shamt == '0) begin
                    ctrl_o.alu_op = r_op;
                    ctrl_o.we     = 1'b1;
                    ctrl_o.re1    = 1'b1;
                    ctrl_o.re2    = 1'b1;
                end
            end
            OPC_ORI: begin
                ctrl_o.alu_op = ALU_OR;
                ctrl_o.imm    = imm_zext;
                i_type        = 1'b1;
            end
            OPC_ANDI: begin
                ctrl_o.alu_op = ALU_AND;
                ctrl_o.imm    = imm_zext;
                i_type        = 1'b1;
            end
            OPC_XORI: begin
                ctrl_o.alu_op = ALU_XOR;
                ctrl_o.imm    = imm_zext;
                i_type        = 1'b1;
            end
            OPC_ADDI, OPC_ADDIU: begin
                ctrl_o.alu_op = ALU_ADD;
                ctrl_o.imm    = imm_sext;
                i_type        = 1'b1;
            end
            OPC_SLTI: begin
                ctrl_o.alu_op = ALU_SLT;
                ctrl_o.imm    = imm_sext;
                i_type        = 1'b1;
            end
            OPC_SLTIU: begin
                ctrl_o.alu_op = ALU_SLTU;
                ctrl_o.imm    = imm_sext;
                i_type        = 1'b1;
            end
            OPC_LUI: begin
                ctrl_o.alu_op = ALU_OR;   // imm | imm
                ctrl_o.imm    = imm_lui;
                i_type        = 1'b1;
            end
            default: ctrl_o.alu_op = ALU_NOP;
        endcase

        if (i_type) begin
            ctrl_o.we    = 1'b1;
            ctrl_o.waddr = rt;
            ctrl_o.re1   = (opcode != OPC_LUI);
        end

        if (ctrl_o.waddr == '0)
            ctrl_o.we = 1'b0;   // r0 is never written
    end

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/10ps

module operand_bypass import id_pkg::*; (
    input  logic      read_en_i,
    input  reg_addr_t addr_i,
    input  word_t     imm_i,
    input  word_t     rf_data_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      wb_fwd_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic wb_hit;

    // younger result wins
    assign ex_hit = read_en_i && ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
    assign wb_hit = read_en_i && wb_fwd_i.we && (wb_fwd_i.addr == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (wb_hit) begin
            operand_o = wb_fwd_i.data;
        end else if (read_en_i) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;      // no register read, immediate path
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps

module reg_file import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  fwd_t      wr_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // r0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* rtl/alu_exec.sv */
`timescale 1ns/10ps

module alu_exec import id_pkg::*; (
    input  logic   clk,
    input  logic   arst_n_i,
    input  id_ex_t id_ex_i,
    output fwd_t   ex_fwd_o,
    output fwd_t   wb_fwd_o
);

    id_ex_t          id_ex_q;
    fwd_t            wb_q;
    word_t           result;
    logic [REG_AW-1:0] sh_amt;

    // ------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_i;
        end
    end

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    assign sh_amt = id_ex_q.op1[REG_AW-1:0];   // low bits only

    always_comb begin
        case (id_ex_q.alu_op)
            ALU_AND: result = id_ex_q.op1 & id_ex_q.op2;
            ALU_OR:  result = id_ex_q.op1 | id_ex_q.op2;
            ALU_XOR: result = id_ex_q.op1 ^ id_ex_q.op2;
            ALU_NOR: result = ~(id_ex_q.op1 | id_ex_q.op2);
            ALU_SLL: result = id_ex_q.op2 << sh_amt;
            ALU_SRL: result = id_ex_q.op2 >> sh_amt;
            ALU_SRA: result = word_t'($signed(id_ex_q.op2) >>> sh_amt);
            ALU_ADD: result = id_ex_q.op1 + id_ex_q.op2;   // wraps, no trap
            ALU_SUB: result = id_ex_q.op1 - id_ex_q.op2;
            ALU_SLT: begin
                result = word_t'($signed(id_ex_q.op1) < $signed(id_ex_q.op2));
            end
            ALU_SLTU: begin
                result = word_t'(id_ex_q.op1 < id_ex_q.op2);
            end
            default: result = '0;
        endcase
    end

    // ex-stage forward, only live for a valid writer
    assign ex_fwd_o.we   = id_ex_q.valid && id_ex_q.we;
    assign ex_fwd_o.addr = id_ex_q.waddr;
    assign ex_fwd_o.data = result;

    // ------------------------------------------------------------
    // EX/WB register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_fwd_o;
        end
    end

    assign wb_fwd_o = wb_q;

endmodule

/* rtl/id_pipe_top.sv */
`timescale 1ns/10ps

module id_pipe_top import id_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  inst_valid_i,
    input  word_t inst_i,
    output fwd_t  wb_o
);

    dec_ctrl_t ctrl;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     operand1;
    word_t     operand2;
    fwd_t      ex_fwd;
    fwd_t      wb_fwd;
    id_ex_t    id_ex;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (wb_fwd),
        .raddr1_i (ctrl.raddr1),
        .raddr2_i (ctrl.raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // ------------------------------------------------------------
    // operand select, one per source
    // ------------------------------------------------------------
    operand_bypass u_byp1 (
        .read_en_i (ctrl.re1),
        .addr_i    (ctrl.raddr1),
        .imm_i     (ctrl.imm),
        .rf_data_i (rf_rdata1),
        .ex_fwd_i  (ex_fwd),
        .wb_fwd_i  (wb_fwd),
        .operand_o (operand1)
    );

    operand_bypass u_byp2 (
        .read_en_i (ctrl.re2),
        .addr_i    (ctrl.raddr2),
        .imm_i     (ctrl.imm),
        .rf_data_i (rf_rdata2),
        .ex_fwd_i  (ex_fwd),
        .wb_fwd_i  (wb_fwd),
        .operand_o (operand2)
    );

    assign id_ex = '{valid: inst_valid_i, alu_op: ctrl.alu_op, we: ctrl.we,
                     waddr: ctrl.waddr, op1: operand1, op2: operand2};

    alu_exec u_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_fwd_o (wb_fwd)
    );

    assign wb_o = wb_fwd;

endmodule

/* tests/tb_id_model.svh */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// ------------------------------------------------------------
// instruction encoders
// ------------------------------------------------------------
function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rs,
                                input reg_addr_t rt, input reg_addr_t rd,
                                input reg_addr_t sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] opc, input reg_addr_t rs,
                                input reg_addr_t rt, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------
word_t model_regs [32];

// architectural result of one instruction, we clear when nothing is written
function automatic fwd_t model_step(input word_t inst);
    fwd_t        res;
    logic [5:0]  opc;
    logic [5:0]  fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   sh;
    word_t       a;
    word_t       b;
    word_t       zx;
    word_t       sx;
    opc = inst[31:26];
    rs  = inst[25:21];
    rt  = inst[20:16];
    rd  = inst[15:11];
    sh  = inst[10:6];
    fn  = inst[5:0];
    a   = model_regs[rs];
    b   = model_regs[rt];
    zx  = {16'h0000, inst[15:0]};
    sx  = {{16{inst[15]}}, inst[15:0]};
    res = '{we: 1'b1, addr: rt, data: '0};
    case (opc)
        6'h00: begin
            res.addr = rd;
            if ((fn inside {6'h00, 6'h02, 6'h03}) ? (rs != 0) : (sh != 0))
                res.we = 1'b0;  // reserved field not zero
            case (fn)
                6'h00: res.data = b << sh;
                6'h02: res.data = b >> sh;
                6'h03: res.data = $signed(b) >>> sh;
                6'h04: res.data = b << a[4:0];
                6'h06: res.data = b >> a[4:0];
                6'h07: res.data = $signed(b) >>> a[4:0];
                6'h20, 6'h21: res.data = a + b;
                6'h22, 6'h23: res.data = a - b;
                6'h24: res.data = a & b;
                6'h25: res.data = a | b;
                6'h26: res.data = a ^ b;
                6'h27: res.data = ~(a | b);
                6'h2a: res.data = {31'b0, $signed(a) < $signed(b)};
                6'h2b: res.data = {31'b0, a < b};
                default: res.we = 1'b0;
            endcase
        end
        6'h08, 6'h09: res.data = a + sx;
        6'h0a: res.data = {31'b0, $signed(a) < $signed(sx)};
        6'h0b: res.data = {31'b0, a < sx};
        6'h0c: res.data = a & zx;
        6'h0d: res.data = a | zx;
        6'h0e: res.data = a ^ zx;
        6'h0f: res.data = {inst[15:0], 16'h0000};
        default: res.we = 1'b0;
    endcase
    if (res.addr == 0)
        res.we = 1'b0;
    return res;
endfunction

`endif

/* tests/tb_id_pipe.sv */
`timescale 1ns/10ps

module tb_id_pipe import id_pkg::*; ();

    localparam int MAX_CYCLES = 3000;   // tests finish well below 800

    logic   clk;
    logic   arst_n_i;
    logic   inst_valid_i;
    word_t  inst_i;
    fwd_t   wb_o;

    fwd_t   exp_q [$];
    int     cycles = 0;
    integer seed;

    `include "tb_id_model.svh"

    id_pipe_top dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_o         (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    // ------------------------------------------------------------
    // monitor, sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        fwd_t exp;
        if (arst_n_i && wb_o.we) begin
            assert (exp_q.size() > 0)
            else report_error($sformatf("unexpected write-back to r%0d", wb_o.addr));
            exp = exp_q.pop_front();
            assert (wb_o.addr == exp.addr && wb_o.data == exp.data)
            else report_error($sformatf("wb r%0d=%h, expected r%0d=%h",
                                        wb_o.addr, wb_o.data, exp.addr, exp.data));
        end
    end

    task automatic issue(input word_t inst);
        fwd_t res;
        res = model_step(inst);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        if (res.we) begin
            exp_q.push_back(res);
            model_regs[res.addr] = res.data;
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        inst_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        idle(2);    // last result is on wb_o two edges after capture
        assert (exp_q.size() == 0)
        else report_error($sformatf("%0d write-backs missing after the pipeline latency",
                                    exp_q.size()));
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        idle(5);    // monitor flags any write here
        issue(enc_r(FN_ADDU, 0, 0, 1, 0));
        drain();
    endtask

    task automatic test_immediates();
        issue(enc_i(OPC_ORI, 0, 1, 16'h1234));
        issue(enc_i(OPC_ORI, 0, 2, 16'h8765));     // zero extended
        issue(enc_i(OPC_LUI, 0, 3, 16'hABCD));
        issue(enc_i(OPC_ORI, 3, 3, 16'hF0F0));
        issue(enc_i(OPC_ANDI, 3, 4, 16'h8FFF));
        issue(enc_i(OPC_ANDI, 3, 5, 16'h00FF));
        issue(enc_i(OPC_XORI, 3, 6, 16'hFFFF));
        issue(enc_i(OPC_XORI, 1, 7, 16'h0F0F));
        issue(enc_i(OPC_ADDI, 1, 8, 16'hFFFE));    // sign extended
        issue(enc_i(OPC_ADDI, 1, 9, 16'h0010));
        issue(enc_i(OPC_ADDIU, 0, 10, 16'h8000));
        issue(enc_i(OPC_ADDIU, 10, 11, 16'h7FFF));
        issue(enc_i(OPC_SLTI, 10, 12, 16'h0001));
        issue(enc_i(OPC_SLTI, 1, 13, 16'hFFFF));
        issue(enc_i(OPC_SLTIU, 10, 14, 16'hFFFF)); // compares with 0xffffffff
        issue(enc_i(OPC_SLTIU, 10, 15, 16'h0001));
        drain();
    endtask

    task automatic test_r_type();
        issue(enc_i(OPC_ADDIU, 0, 16, 16'hFFF0));  // -16
        issue(enc_i(OPC_ORI, 0, 17, 16'h0025));
        issue(enc_i(OPC_LUI, 0, 18, 16'h8000));
        issue(enc_r(FN_AND, 16, 17, 19, 0));
        issue(enc_r(FN_OR, 16, 17, 20, 0));
        issue(enc_r(FN_XOR, 16, 18, 21, 0));
        issue(enc_r(FN_NOR, 17, 18, 22, 0));
        issue(enc_r(FN_ADD, 16, 17, 23, 0));
        issue(enc_r(FN_ADD, 18, 18, 24, 0));       // wraps, no trap
        issue(enc_r(FN_ADDU, 16, 16, 25, 0));
        issue(enc_r(FN_SUB, 17, 16, 26, 0));
        issue(enc_r(FN_SUBU, 18, 17, 27, 0));
        issue(enc_r(FN_SLT, 16, 17, 28, 0));
        issue(enc_r(FN_SLT, 17, 16, 29, 0));
        issue(enc_r(FN_SLTU, 16, 17, 30, 0));
        issue(enc_r(FN_SLTU, 17, 18, 31, 0));
        drain();
    endtask

    task automatic test_shifts();
        issue(enc_i(OPC_LUI, 0, 10, 16'hF000));
        issue(enc_i(OPC_ORI, 10, 10, 16'h0001));
        issue(enc_i(OPC_ADDIU, 0, 12, 16'hFFE3));  // low bits give 3
        issue(enc_r(FN_SLL, 0, 10, 11, 0));
        issue(enc_r(FN_SLL, 0, 10, 13, 1));
        issue(enc_r(FN_SLL, 0, 10, 14, 31));
        issue(enc_r(FN_SRL, 0, 10, 15, 0));
        issue(enc_r(FN_SRL, 0, 10, 16, 1));
        issue(enc_r(FN_SRL, 0, 10, 17, 31));
        issue(enc_r(FN_SRA, 0, 10, 18, 0));
        issue(enc_r(FN_SRA, 0, 10, 19, 1));
        issue(enc_r(FN_SRA, 0, 10, 20, 31));
        issue(enc_r(FN_SLLV, 12, 10, 21, 0));
        issue(enc_r(FN_SRLV, 12, 10, 22, 0));
        issue(enc_r(FN_SRAV, 12, 10, 23, 0));
        drain();
    endtask

    task automatic test_forwarding();
        issue(enc_i(OPC_ADDIU, 0, 2, 16'h0005));
        issue(enc_r(FN_ADDU, 2, 2, 3, 0));         // distance 1
        issue(enc_i(OPC_ADDIU, 0, 4, 16'h0007));
        issue(enc_i(OPC_ORI, 0, 9, 16'h0001));
        issue(enc_r(FN_ADDU, 4, 4, 5, 0));         // distance 2
        issue(enc_i(OPC_ADDIU, 0, 4, 16'h0009));
        issue(enc_i(OPC_ORI, 0, 9, 16'h0002));
        issue(enc_i(OPC_ORI, 0, 9, 16'h0003));
        issue(enc_r(FN_ADDU, 4, 4, 5, 0));         // distance 3
        issue(enc_i(OPC_ADDIU, 0, 6, 16'h0001));
        issue(enc_i(OPC_ADDIU, 0, 6, 16'h0002));
        issue(enc_r(FN_ADDU, 6, 6, 7, 0));         // ex beats wb
        issue(enc_i(OPC_ADDIU, 0, 0, 16'h0037));   // r0 write, no wb
        issue(enc_r(FN_ADDU, 0, 0, 8, 0));
        issue(enc_i(OPC_ORI, 0, 0, 16'hFFFF));
        idle(1);
        issue(enc_r(FN_OR, 0, 0, 8, 0));
        drain();
    endtask

    task automatic test_bubbles_random();
        logic [5:0] r_fn  [16];
        logic [5:0] i_opc [8];
        word_t      inst;
        int         kind;
        reg_addr_t  rs;
        reg_addr_t  sh;
        r_fn  = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
                  FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
        i_opc = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI, OPC_XORI,
                  OPC_LUI};
        // unknown encodings are bubbles
        issue(enc_i(6'h23, 1, 2, 16'h0000));
        issue(enc_i(6'h3f, 3, 4, 16'h1234));
        issue(enc_r(6'h3f, 1, 2, 3, 0));
        issue(enc_r(FN_ADDU, 1, 2, 3, 5));
        inst_i = enc_r(FN_ADDU, 1, 2, 3, 0);       // decodable but not valid
        idle(4);
        seed = 7245;
        repeat (300) begin
            kind = ($random(seed) & 32'h7fffffff) % 24;
            inst = $random(seed);
            if (kind < 16) begin
                rs = inst[25:21];
                sh = inst[10:6];
                if (kind < 3)
                    rs = 0;
                else
                    sh = 0;
                inst = enc_r(r_fn[kind], rs, inst[20:16], inst[15:11], sh);
            end else begin
                inst = enc_i(i_opc[kind-16], inst[25:21], inst[20:16], inst[15:0]);
            end
            issue(inst);
            if (($random(seed) & 7) == 0)
                idle(1);
        end
        drain();
    endtask

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        seed         = 7245;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        test_reset();
        test_immediates();
        test_r_type();
        test_shifts();
        test_forwarding();
        test_bubbles_random();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* mips_id.f */
+incdir+tests
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/id_pipe_top.sv
tests/tb_id_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the id pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f mips_id.f --top-module tb_id_pipe -o sim_id_pipe

# the simulator exits nonzero on failure, the log decides
./obj_dir/sim_id_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
